// ==== all.f ====
+incdir+common
common/fetch_pkg.sv
common/axi_pkg.sv
hw/fetch/fetch_pc_stage.sv
hw/fetch/fetch_queue.sv
hw/icache/icache.sv
hw/fetch_unit_top.sv
verification/axi_lite_mem_model.sv
verification/fetch_unit_properties.sv
verification/fetch_unit_tb.sv

// ==== common/axi_pkg.sv ====
`include "fetch_consts.svh"

package axi_pkg;

	////////////////////////////////////////
	// axi4-lite read channel types
	////////////////////////////////////////

	typedef logic [`ADDR_WIDTH-1:0] axi_addr_t;  // araddr
	typedef logic [`BLOCK_WIDTH-1:0] axi_data_t; // rdata, one whole line

	// rresp codes
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// cache refill machine
	typedef enum logic [1:0]
	{
		REFILL_IDLE = 2'b00, // waiting for a miss
		REFILL_ADDR = 2'b01, // arvalid up, waiting on arready
		REFILL_DATA = 2'b10  // rready up, waiting on rvalid
	} refill_state_e;

endpackage

// ==== common/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define ADDR_WIDTH 64        // pc and byte address, one 64-bit word
`define INST_WIDTH 32        // one instruction
`define BLOCK_WIDTH 64       // fetch block = cache line = two instructions

////////////////////////////////////////
// sizes
////////////////////////////////////////

`define ICACHE_LINES 32      // direct mapped, one block per line
`define FETCH_QUEUE_DEPTH 8  // must stay a power of two, pointers wrap

// first pc fetched out of reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

// ==== common/fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

	////////////////////////////////////////
	// instruction side types
	////////////////////////////////////////

	// pc or byte address
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// one instruction word
	typedef logic [`INST_WIDTH-1:0] inst_t;

	// one fetch block, lower half is the even-word instruction
	// upper half is the odd-word one (pc bit 2 set)
	typedef logic [`BLOCK_WIDTH-1:0] block_t;

	// request from the pc stage to the cache
	typedef enum logic
	{
		FETCH_NONE = 1'b0, // no lookup, no refill
		FETCH_LOAD = 1'b1  // lookup and refill on a miss
	} fetch_cmd_e;

endpackage

// ==== hw/fetch/fetch_pc_stage.sv ====
`include "fetch_consts.svh"

module fetch_pc_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  redirect,    // mispredict stand-in
	input  fetch_pkg::addr_t      redirect_pc,
	input  logic                  stall,       // queue can't take two more
	input  logic                  hit,         // from icache, same cycle
	input  fetch_pkg::block_t     block_data,
	output fetch_pkg::addr_t      fetch_addr,  // block aligned pc
	output fetch_pkg::fetch_cmd_e fetch_cmd,
	output fetch_pkg::inst_t      inst0,
	output fetch_pkg::addr_t      inst0_pc,
	output logic                  inst0_valid,
	output fetch_pkg::inst_t      inst1,
	output fetch_pkg::addr_t      inst1_pc,
	output logic                  inst1_valid
);
	import fetch_pkg::*;

	addr_t pc;           // current fetch pc
	addr_t next_pc;
	logic  reset_flag;   // high for the first cycle out of reset
	logic  odd_word;     // pc points at the upper half of the block
	logic  take;         // block accepted this cycle
	inst_t lo_inst;
	inst_t hi_inst;

	////////////////////////////////////////
	// cache request
	////////////////////////////////////////

	assign fetch_addr = {pc[`ADDR_WIDTH-1:3], 3'b000}; // drop block offset

	// one idle cycle after reset, then always loading
	assign fetch_cmd = reset_flag ? FETCH_NONE : FETCH_LOAD;

	////////////////////////////////////////
	// block split
	////////////////////////////////////////

	assign lo_inst  = block_data[`INST_WIDTH-1:0];
	assign hi_inst  = block_data[`BLOCK_WIDTH-1:`INST_WIDTH];
	assign odd_word = pc[2];

	// redirect cycle and first cycle after reset deliver nothing
	assign take = hit && !stall && !redirect && !reset_flag;

	// odd pc: only the upper word goes out, and it goes in slot 0
	assign inst0    = odd_word ? hi_inst : lo_inst;
	assign inst0_pc = pc;
	assign inst1    = hi_inst;
	assign inst1_pc = fetch_addr + addr_t'(4); // upper word of this block

	assign inst0_valid = take;
	assign inst1_valid = take && !odd_word; // never without inst0

	////////////////////////////////////////
	// next pc
	////////////////////////////////////////

	always_comb
	begin
		next_pc = pc; // hold on miss, stall or the post-reset cycle
		if (redirect)
		begin
			next_pc = redirect_pc;
		end
		else if (take)
		begin
			// step to next block start
			if (odd_word)
			begin
				next_pc = pc + addr_t'(4);
			end
			else
			begin
				next_pc = pc + addr_t'(8);
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc         <= `RESET_PC;
			reset_flag <= 1'b1;
		end
		else
		begin
			pc         <= next_pc;
			reset_flag <= 1'b0;
		end
	end

endmodule

// ==== hw/fetch/fetch_queue.sv ====
`include "fetch_consts.svh"

module fetch_queue (
	input  logic             clock,
	input  logic             reset,
	input  logic             flush,        // redirect, drop everything
	input  fetch_pkg::inst_t inst0,
	input  fetch_pkg::addr_t inst0_pc,
	input  logic             inst0_valid,
	input  fetch_pkg::inst_t inst1,
	input  fetch_pkg::addr_t inst1_pc,
	input  logic             inst1_valid,
	output logic             full,         // fewer than two free slots
	output logic             decode_valid,
	output fetch_pkg::inst_t decode_inst,
	output fetch_pkg::addr_t decode_pc,
	input  logic             decode_ready
);
	import fetch_pkg::*;

	localparam int PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1; // count reaches depth

	inst_t inst_mem [`FETCH_QUEUE_DEPTH];
	addr_t pc_mem   [`FETCH_QUEUE_DEPTH];

	logic [PTR_W-1:0] head;     // oldest entry
	logic [PTR_W-1:0] tail;     // next free slot
	logic [CNT_W-1:0] count;
	logic [1:0]       push_cnt; // 0, 1 or 2 this cycle
	logic             pop;

	////////////////////////////////////////
	// decode side
	////////////////////////////////////////

	assign decode_valid = (count != '0);
	assign decode_inst  = inst_mem[head]; // head only moves on pop
	assign decode_pc    = pc_mem[head];
	assign pop          = decode_valid && decode_ready;

	assign full = count > CNT_W'(`FETCH_QUEUE_DEPTH - 2);

	// inst1 only ever valid together with inst0
	assign push_cnt = {1'b0, inst0_valid} + {1'b0, inst1_valid};

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (inst0_valid)
		begin
			inst_mem[tail] <= inst0;
			pc_mem[tail]   <= inst0_pc;
		end
		if (inst1_valid)
		begin
			inst_mem[tail + PTR_W'(1)] <= inst1; // wraps with the pointer
			pc_mem[tail + PTR_W'(1)]   <= inst1_pc;
		end
	end

	// pointers and count
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			tail  <= tail + PTR_W'(push_cnt);
			head  <= head + PTR_W'(pop);
			count <= count + CNT_W'(push_cnt) - CNT_W'(pop);
		end
	end

endmodule

// ==== hw/fetch_unit_top.sv ====
module fetch_unit_top (
	input  logic               clock,
	input  logic               reset,
	input  logic               redirect,
	input  fetch_pkg::addr_t   redirect_pc,
	output logic               decode_valid,
	output fetch_pkg::inst_t   decode_inst,
	output fetch_pkg::addr_t   decode_pc,
	input  logic               decode_ready,
	output axi_pkg::axi_addr_t araddr,
	output logic               arvalid,
	input  logic               arready,
	input  logic               rvalid,
	input  axi_pkg::axi_data_t rdata,
	input  axi_pkg::axi_resp_e rresp,
	output logic               rready
);
	import fetch_pkg::*;

	addr_t      fetch_addr;  // pc stage -> icache
	fetch_cmd_e fetch_cmd;
	logic       hit;         // icache -> pc stage
	block_t     block_data;
	inst_t      inst0;       // pc stage -> queue
	addr_t      inst0_pc;
	logic       inst0_valid;
	inst_t      inst1;
	addr_t      inst1_pc;
	logic       inst1_valid;
	logic       queue_full;  // back to pc stage as the stall

	fetch_pc_stage pc_stage (
		.clock       (clock),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.stall       (queue_full),
		.hit         (hit),
		.block_data  (block_data),
		.fetch_addr  (fetch_addr),
		.fetch_cmd   (fetch_cmd),
		.inst0       (inst0),
		.inst0_pc    (inst0_pc),
		.inst0_valid (inst0_valid),
		.inst1       (inst1),
		.inst1_pc    (inst1_pc),
		.inst1_valid (inst1_valid)
	);

	icache cache (
		.clock      (clock),
		.reset      (reset),
		.fetch_addr (fetch_addr),
		.fetch_cmd  (fetch_cmd),
		.hit        (hit),
		.block_data (block_data),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.rready     (rready)
	);

	// redirect also flushes whatever was queued on the old path
	fetch_queue queue (
		.clock        (clock),
		.reset        (reset),
		.flush        (redirect),
		.inst0        (inst0),
		.inst0_pc     (inst0_pc),
		.inst0_valid  (inst0_valid),
		.inst1        (inst1),
		.inst1_pc     (inst1_pc),
		.inst1_valid  (inst1_valid),
		.full         (queue_full),
		.decode_valid (decode_valid),
		.decode_inst  (decode_inst),
		.decode_pc    (decode_pc),
		.decode_ready (decode_ready)
	);

endmodule

// ==== hw/icache/icache.sv ====
`include "fetch_consts.svh"

module icache (
	input  logic                  clock,
	input  logic                  reset,
	input  fetch_pkg::addr_t      fetch_addr,
	input  fetch_pkg::fetch_cmd_e fetch_cmd,
	output logic                  hit,
	output fetch_pkg::block_t     block_data,
	// axi4-lite read master
	output axi_pkg::axi_addr_t    araddr,
	output logic                  arvalid,
	input  logic                  arready,
	input  logic                  rvalid,
	input  axi_pkg::axi_data_t    rdata,
	input  axi_pkg::axi_resp_e    rresp,
	output logic                  rready
);
	import fetch_pkg::*;
	import axi_pkg::*;

	localparam int OFFSET_W = $clog2(`BLOCK_WIDTH / 8);          // byte offset in a line
	localparam int INDEX_W  = $clog2(`ICACHE_LINES);
	localparam int TAG_W    = `ADDR_WIDTH - INDEX_W - OFFSET_W;

	block_t             data_mem [`ICACHE_LINES];
	logic [TAG_W-1:0]   tag_mem  [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] valid_bits;

	logic [INDEX_W-1:0] look_index;
	logic [TAG_W-1:0]   look_tag;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0]   fill_tag;
	logic               miss_start;
	logic               fill_done;   // r beat taken this cycle
	refill_state_e      state;
	axi_addr_t          refill_addr; // held from miss to r beat

	////////////////////////////////////////
	// lookup, purely combinational
	////////////////////////////////////////

	assign look_index = fetch_addr[OFFSET_W +: INDEX_W];
	assign look_tag   = fetch_addr[`ADDR_WIDTH-1 -: TAG_W];

	assign hit        = valid_bits[look_index] && (tag_mem[look_index] == look_tag);
	assign block_data = data_mem[look_index];

	// one refill at a time, a second miss waits for idle
	assign miss_start = (fetch_cmd == FETCH_LOAD) && !hit && (state == REFILL_IDLE);

	////////////////////////////////////////
	// refill machine
	////////////////////////////////////////

	assign araddr  = refill_addr;               // stable for the whole request
	assign arvalid = (state == REFILL_ADDR);
	assign rready  = (state == REFILL_DATA);

	assign fill_index = refill_addr[OFFSET_W +: INDEX_W];
	assign fill_tag   = refill_addr[`ADDR_WIDTH-1 -: TAG_W];
	assign fill_done  = rready && rvalid;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= REFILL_IDLE;
		end
		else
		begin
			case (state)
				REFILL_IDLE:
				begin
					if (miss_start)
					begin
						state <= REFILL_ADDR;
					end
				end
				REFILL_ADDR:
				begin
					if (arready)
					begin
						state <= REFILL_DATA; // ar accepted
					end
				end
				REFILL_DATA:
				begin
					if (rvalid)
					begin
						state <= REFILL_IDLE; // error or not, lookup retries
					end
				end
				default:
				begin
					state <= REFILL_IDLE;
				end
			endcase
		end
	end

	// capture the block address on the miss
	always_ff @(posedge clock)
	begin
		if (miss_start)
		begin
			refill_addr <= fetch_addr;
		end
	end

	////////////////////////////////////////
	// line write
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (fill_done && (rresp == OKAY))
		begin
			data_mem[fill_index] <= rdata;
			tag_mem[fill_index]  <= fill_tag;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_bits <= '0;
		end
		else if (fill_done)
		begin
			valid_bits[fill_index] <= (rresp == OKAY); // bad response keeps it invalid
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fetch unit testbench with verilator, run it, scan the log

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module fetch_unit_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build returned an error"
	exit 1
fi

./obj_dir/Vfetch_unit_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$log"; then
	exit 1
fi
exit 0

// ==== verification/axi_lite_mem_model.sv ====
module axi_lite_mem_model (
	input  logic               clock,
	input  logic               reset,
	input  axi_pkg::axi_addr_t araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic               rvalid,
	output axi_pkg::axi_data_t rdata,
	output axi_pkg::axi_resp_e rresp,
	input  logic               rready
);
	timeunit 1ns;
	timeprecision 100ps;

	import axi_pkg::*;

	localparam int MAX_WAIT = 5; // extra cycles before arready and before rvalid

	typedef enum logic [2:0]
	{
		M_IDLE,
		M_AR_WAIT, // counting down to arready
		M_AR_ACK,  // arready up, ar taken on this edge
		M_R_WAIT,  // counting down to rvalid
		M_R_ACK    // rvalid up until rready
	} mem_state_e;

	// contents follow from the address alone
	// lower half is the even word, upper half the odd word
	function automatic axi_data_t block_at(input axi_addr_t a);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = {a[31:3], 3'b000} ^ 32'h5a5a0000;
		hi = {a[31:3], 3'b100} ^ 32'h5a5a0000;
		return {hi, lo};
	endfunction

	// single process so that all draws come from the one seeded generator
	initial
	begin
		mem_state_e state;
		int         wait_cnt;
		axi_addr_t  addr;     // block address of the accepted request
		arready  = 1'b0;
		rvalid   = 1'b0;
		rdata    = '0;
		rresp    = OKAY;
		state    = M_IDLE;
		wait_cnt = 0;
		addr     = '0;
		void'($urandom(32'hdd3ec91f));
		forever
		begin
			@(posedge clock); // inputs read here are pre-edge values
			if (reset)
			begin
				arready <= 1'b0;
				rvalid  <= 1'b0;
				state   = M_IDLE;
			end
			else
			begin
				case (state)
					M_IDLE:
					begin
						if (arvalid)
						begin
							wait_cnt = int'($urandom % (MAX_WAIT + 1));
							state    = M_AR_WAIT;
						end
					end
					M_AR_WAIT:
					begin
						if (wait_cnt == 0)
						begin
							arready <= 1'b1;
							state   = M_AR_ACK;
						end
						else
						begin
							wait_cnt--;
						end
					end
					M_AR_ACK:
					begin
						arready  <= 1'b0;
						addr     = araddr; // arvalid and arready both high this cycle
						wait_cnt = int'($urandom % (MAX_WAIT + 1));
						state    = M_R_WAIT;
					end
					M_R_WAIT:
					begin
						if (wait_cnt == 0)
						begin
							rvalid <= 1'b1;
							rdata  <= block_at(addr);
							rresp  <= OKAY;
							state  = M_R_ACK;
						end
						else
						begin
							wait_cnt--;
						end
					end
					default:
					begin
						if (rready) // beat taken on this edge
						begin
							rvalid <= 1'b0;
							state  = M_IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== verification/fetch_unit_properties.sv ====
module fetch_unit_properties (
	input logic               clock,
	input logic               reset,
	input logic               redirect,
	input axi_pkg::axi_addr_t araddr,
	input logic               arvalid,
	input logic               arready,
	input logic               decode_valid,
	input fetch_pkg::inst_t   decode_inst,
	input fetch_pkg::addr_t   decode_pc,
	input logic               decode_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// failure counts, one per assertion
	int unsigned ar_fails     = 0;
	int unsigned decode_fails = 0;
	int unsigned reset_fails  = 0;

	////////////////////////////////////////
	// handshakes
	////////////////////////////////////////

	// ar request held with the same address until accepted
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
	else
	begin
		$error("ar request changed before arready");
		ar_fails++;
	end

	// decode output held until taken, a redirect may drop it
	decode_hold: assert property (@(posedge clock) disable iff (reset)
		decode_valid && !decode_ready && !redirect |=>
			decode_valid && $stable(decode_inst) && $stable(decode_pc))
	else
	begin
		$error("decode output changed before decode_ready");
		decode_fails++;
	end

	// mid-cycle check, flops are already reset after the first edge
	reset_quiet: assert property (@(negedge clock)
		reset |-> !arvalid && !decode_valid)
	else
	begin
		$error("arvalid or decode_valid high during reset");
		reset_fails++;
	end

endmodule

bind fetch_unit_top fetch_unit_properties props (.*);

// ==== verification/fetch_unit_tb.sv ====
module fetch_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fetch_pkg::*;
	import axi_pkg::*;

	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_INST = 200; // watchdog allowance
	localparam int AR_ANY          = 0;   // ar transfers not checked
	localparam int AR_NONE         = 1;   // whole row served from the cache
	localparam int AR_SOME         = 2;   // lines replaced, refills expected

	logic      clock = 1'b0;
	logic      reset;
	logic      redirect;
	addr_t     redirect_pc;
	logic      decode_valid;
	inst_t     decode_inst;
	addr_t     decode_pc;
	logic      decode_ready;
	axi_addr_t araddr;
	logic      arvalid;
	logic      arready;
	logic      rvalid;
	axi_data_t rdata;
	axi_resp_e rresp;
	logic      rready;

	// test table, one row per test
	addr_t row_pc    [NUM_TESTS]; // start pc, row 0 starts from reset
	int    row_count [NUM_TESTS]; // instructions to take
	logic  row_slow  [NUM_TESTS]; // decode_ready only every third cycle
	int    row_ar    [NUM_TESTS];

	int unsigned ar_count     = 0;
	int          error_count  = 0;
	int          bad_tests    = 0;
	int          budget       = 0;
	logic        table_loaded = 1'b0;

	always #50 clock = ~clock;

	fetch_unit_top dut (.*);

	axi_lite_mem_model mem (.*);

	// ar transfers at the top-level ports, sampled mid-cycle
	always @(negedge clock)
	begin
		if (!reset && arvalid && arready)
		begin
			ar_count++;
		end
	end

	task automatic set_row(input int r, input addr_t pc, input int n, input logic slow,
			input int ar);
		row_pc[r]    = pc;
		row_count[r] = n;
		row_slow[r]  = slow;
		row_ar[r]    = ar;
	endtask

	// memory rule: word address with low bits clear, xor fixed pattern
	function automatic inst_t expected_inst(input addr_t pc);
		return {pc[31:3], pc[2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	// refill port quiet for 8 cycles means no refill left in flight
	task automatic wait_refill_idle();
		int quiet;
		quiet = 0;
		while (quiet < 8)
		begin
			@(negedge clock);
			if (arvalid || rready)
			begin
				quiet = 0;
			end
			else
			begin
				quiet++;
			end
		end
	endtask

	////////////////////////////////////////
	// one table row
	////////////////////////////////////////

	task automatic run_test(input int r);
		addr_t       exp_pc;
		int          taken;
		int          phase;
		int          errs;
		int unsigned ar_start;
		int unsigned ar_used;
		exp_pc   = row_pc[r];
		taken    = 0;
		phase    = 0;
		errs     = 0;
		ar_start = ar_count;
		if (r != 0)
		begin
			@(posedge clock);
			redirect    <= 1'b1; // one-cycle pulse, also flushes the queue
			redirect_pc <= row_pc[r];
		end
		while (taken < row_count[r])
		begin
			@(posedge clock);
			redirect     <= 1'b0;
			decode_ready <= !row_slow[r] || (phase == 0);
			phase        = (phase + 1) % 3;
			@(negedge clock);
			if (decode_valid && decode_ready) // transfers on the next edge
			begin
				if (decode_pc !== exp_pc)
				begin
					$display("MISMATCH test %0d decode_pc: got %h, expected %h",
						r, decode_pc, exp_pc);
					errs++;
				end
				if (decode_inst !== expected_inst(exp_pc))
				begin
					$display("MISMATCH test %0d decode_inst: got %h, expected %h",
						r, decode_inst, expected_inst(exp_pc));
					errs++;
				end
				exp_pc = exp_pc + addr_t'(4); // in order, one word each
				taken++;
			end
		end
		@(posedge clock); // last item goes on this edge
		decode_ready <= 1'b0;
		ar_used = ar_count - ar_start;
		if (row_ar[r] == AR_NONE && ar_used != 0)
		begin
			$display("test %0d: %0d AR transfers while refetching lines that were cached",
				r, ar_used);
			errs++;
		end
		if (row_ar[r] == AR_SOME && ar_used == 0)
		begin
			$display("test %0d: no AR transfer although the lines had been replaced", r);
			errs++;
		end
		$display("test %0d: start %h, %0d taken, %0d ar, %0d errors, %s",
			r, row_pc[r], taken, ar_used, errs, (errs == 0) ? "ok" : "bad");
		error_count += errs;
		if (errs != 0)
		begin
			bad_tests++;
		end
		wait_refill_idle(); // queue fills meanwhile, pc freezes
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int assert_errors;
		reset        = 1'b1;
		redirect     = 1'b0;
		redirect_pc  = '0;
		decode_ready = 1'b0;
		set_row(0, 64'h0000, 16, 1'b0, AR_ANY);  // from reset pc
		set_row(1, 64'h0000, 16, 1'b0, AR_NONE); // refetch from cache
		set_row(2, 64'h1000, 16, 1'b0, AR_ANY);  // index 0 again, other tag
		set_row(3, 64'h0000, 16, 1'b0, AR_SOME); // evicted, refills again
		set_row(4, 64'h0104, 16, 1'b0, AR_ANY);  // odd-word start
		set_row(5, 64'h0100, 24, 1'b1, AR_ANY);  // lines warm from row 4, fetch outruns decode
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			budget += row_count[i] * CYCLES_PER_INST;
		end
		table_loaded = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < NUM_TESTS; r++)
		begin
			run_test(r);
		end
		assert_errors = int'(dut.props.ar_fails + dut.props.decode_fails
			+ dut.props.reset_fails);
		$display("summary: %0d tests run, %0d bad, %0d check errors, %0d assertion errors",
			NUM_TESTS, bad_tests, error_count, assert_errors);
		if (error_count == 0 && assert_errors == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog sized from the table
	initial
	begin
		wait (table_loaded);
		repeat (budget + 8) @(posedge clock);
		$display("watchdog: run still going after %0d cycles", budget + 8);
		$display("tests failed");
		$finish;
	end

endmodule
